//--- hw/aspect_window.sv
// Aspect-ratio display window
// Free-running eight phase sequencer that scales the picture to
// the requested aspect ratio and centres it in the active area.
// Zero aspect terms select the full active area

`timescale 1ns/1ps

module aspect_window (
	input  logic                  clk_sys,
	input  logic                  resetd,
	av_cfg_if.cfg_dst             i_cfg,
	input  av_types_pkg::aspect_t i_arx,
	input  av_types_pkg::aspect_t i_ary,
	output av_types_pkg::coord_t  o_hmin,
	output av_types_pkg::coord_t  o_hmax,
	output av_types_pkg::coord_t  o_vmin,
	output av_types_pkg::coord_t  o_vmax
);

	typedef enum logic [2:0] {
		PH_CALC,
		PH_WAIT1,
		PH_WAIT2,
		PH_WAIT3,
		PH_WAIT4,
		PH_WAIT5,
		PH_CLAMP,
		PH_PLACE
	} phase_t;

	phase_t phase;

	// Products of 12 and 8 bits, divided by a nonzero 8 bit term
	logic [19:0] wcalc;
	logic [19:0] hcalc;

	av_types_pkg::coord_t videow;
	av_types_pkg::coord_t videoh;
	av_types_pkg::coord_t base_h;
	av_types_pkg::coord_t hoff;
	av_types_pkg::coord_t voff;

	// Height the width is scaled from
	assign base_h = (i_cfg.vset != '0) ? i_cfg.vset : i_cfg.height;

	// Left and top margins
	assign hoff = av_types_pkg::coord_t'(i_cfg.width - videow) >> 1;
	assign voff = av_types_pkg::coord_t'(i_cfg.height - videoh) >> 1;

	//////////////////////////////
	// Phase sequencer
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			phase <= PH_CALC;
		end else if (phase == PH_CALC && (i_arx == '0 || i_ary == '0)) begin
			phase <= PH_CALC;
		end else begin
			// PH_PLACE wraps back to PH_CALC
			phase <= phase_t'(phase + 3'd1);
		end
	end

	//////////////////////////////
	// Scaled size
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (phase == PH_CALC) begin
			wcalc <= (20'(base_h) * 20'(i_arx)) / 20'(i_ary);
			hcalc <= (20'(i_cfg.width) * 20'(i_ary)) / 20'(i_arx);
		end
		if (phase == PH_CLAMP) begin
			if (i_cfg.vset == '0 && wcalc > 20'(i_cfg.width)) begin
				videow <= i_cfg.width;
			end else begin
				videow <= wcalc[11:0];
			end
			if (i_cfg.vset != '0) begin
				videoh <= i_cfg.vset;
			end else if (hcalc > 20'(i_cfg.height)) begin
				videoh <= i_cfg.height;
			end else begin
				videoh <= hcalc[11:0];
			end
		end
	end

	//////////////////////////////
	// Window outputs
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_hmin <= '0;
			o_hmax <= '0;
			o_vmin <= '0;
			o_vmax <= '0;
		end else if (phase == PH_CALC && (i_arx == '0 || i_ary == '0)) begin
			// No aspect given, use the whole active area
			o_hmin <= '0;
			o_hmax <= i_cfg.width - 12'd1;
			o_vmin <= '0;
			o_vmax <= i_cfg.height - 12'd1;
		end else if (phase == PH_PLACE) begin
			o_hmin <= hoff;
			o_hmax <= hoff + videow - 12'd1;
			o_vmin <= voff;
			o_vmax <= voff + videoh - 12'd1;
		end
	end

endmodule

//--- hw/audio_channel_mix.sv
// One channel of the stereo audio mixer
// Deglitches core audio, adds the auxiliary stream, blends in
// the other channel, attenuates and saturates to 16 bits

`timescale 1ns/1ps

module audio_channel_mix (
	input  logic                    clk_sys,
	input  logic                    resetd,
	input  av_types_pkg::sample_t   i_core,
	input  av_types_pkg::sample_t   i_aux,
	input  av_types_pkg::sample_t   i_pre,
	input  logic                    i_signed,
	input  av_types_pkg::mix_mode_t i_mix,
	av_cfg_if.cfg_dst               i_cfg,
	output av_types_pkg::sample_t   o_pre,
	output av_types_pkg::sample_t   o_out
);

	av_types_pkg::sample_t d1;
	av_types_pkg::sample_t d2;
	av_types_pkg::sample_t d3;
	av_types_pkg::sample_t ca;

	logic signed [16:0] a1;
	logic signed [16:0] a2;
	logic signed [16:0] a3;
	logic signed [16:0] a4;
	logic signed [16:0] pre_x;
	logic signed [16:0] aux_x;

	assign pre_x = {i_pre[15], i_pre};
	assign aux_x = {i_aux[15], i_aux};

	//////////////////////////////
	// Deglitch
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			d1 <= '0;
			d2 <= '0;
			d3 <= '0;
			ca <= '0;
		end else begin
			d1 <= i_core;
			d2 <= d1;
			d3 <= d2;
			// Pass only a sample seen twice in a row
			if (d2 == d3) begin
				ca <= d2;
			end
		end
	end

	//////////////////////////////
	// Mix pipeline
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			a1    <= '0;
			a2    <= '0;
			a3    <= '0;
			a4    <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// Unsigned core audio loses one bit to fit the signed range
			a1 <= i_signed ? {ca[15], ca} : {2'b00, ca[15:1]};
			a2 <= a1 + aux_x;

			o_pre <= a2[16:1];

			case (i_mix)
				av_types_pkg::MIX_NONE: a3 <= a2;
				av_types_pkg::MIX_LOW:  a3 <= a2 - (a2 >>> 3) + (pre_x >>> 2);
				av_types_pkg::MIX_MID:  a3 <= a2 - (a2 >>> 2) + (pre_x >>> 1);
				default:                a3 <= (a2 >>> 1) + pre_x;
			endcase

			if (i_cfg.vol_att[4]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_cfg.vol_att[3:0];
			end

			// Clamp to 16 bit signed
			o_out <= (a4[16] ^ a4[15]) ? {a4[16], {15{a4[15]}}} : a4[15:0];
		end
	end

endmodule

//--- hw/av_cfg_if.sv
// Decoded configuration bus
// Carries active size, vertical override and volume
// from the host command decoder to the video and audio blocks

`timescale 1ns/1ps

interface av_cfg_if;

	// Active area
	av_types_pkg::coord_t width;
	av_types_pkg::coord_t height;

	// Vertical size override, 0 when unused
	av_types_pkg::coord_t vset;

	// Volume attenuation
	av_types_pkg::att_t vol_att;

	modport cfg_src (
		output width,
		output height,
		output vset,
		output vol_att
	);

	modport cfg_dst (
		input width,
		input height,
		input vset,
		input vol_att
	);

endinterface

//--- hw/av_types_pkg.sv
// Video and audio types shared by the A/V controller
// Window coordinates, aspect terms, audio samples, attenuation
// and the crossfeed mode of the stereo mixer

package av_types_pkg;

	// Pixel count or pixel position
	typedef logic [11:0] coord_t;

	// One term of an aspect ratio
	typedef logic [7:0] aspect_t;

	// Audio sample, signed or offset binary
	typedef logic [15:0] sample_t;

	// Bit 4 mutes, bits 3:0 give the right shift
	typedef logic [4:0] att_t;

	// Crossfeed between the two channels
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_LOW  = 2'd1,
		MIX_MID  = 2'd2,
		MIX_MONO = 2'd3
	} mix_mode_t;

	// Active area after reset, 1080p
	parameter coord_t DEF_WIDTH  = 12'd1920;
	parameter coord_t DEF_HEIGHT = 12'd1080;

endpackage

//--- hw/host_cmd_decoder.sv
// Host command decoder
// First strobed word after select rises is the command, the
// words after it are data. Handles video timing, volume
// attenuation and vertical size override; anything else is dropped

`timescale 1ns/1ps

module host_cmd_decoder #(
	parameter av_types_pkg::coord_t RESET_WIDTH  = av_types_pkg::DEF_WIDTH,
	parameter av_types_pkg::coord_t RESET_HEIGHT = av_types_pkg::DEF_HEIGHT
) (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_io_sel,
	input  logic                   i_io_strobe,
	input  host_cmd_pkg::io_word_t i_io_din,
	av_cfg_if.cfg_src              o_cfg
);

	// Last timing word index worth tracking, everything past it is ignored
	localparam logic [2:0] IDX_LAST = 3'd5;

	logic       has_cmd;
	logic [7:0] cmd;
	logic [2:0] word_idx;

	//////////////////////////////
	// Command state
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd  <= 1'b0;
			cmd      <= 8'h00;
			word_idx <= 3'd0;
		end else if (!i_io_sel) begin
			// Select dropped, forget the pending command
			has_cmd  <= 1'b0;
			cmd      <= 8'h00;
			word_idx <= 3'd0;
		end else if (i_io_strobe) begin
			if (!has_cmd) begin
				has_cmd  <= 1'b1;
				cmd      <= i_io_din[7:0];
				word_idx <= 3'd0;
			end else if (word_idx != IDX_LAST) begin
				// Saturate so long streams never wrap back onto width
				word_idx <= word_idx + 3'd1;
			end
		end
	end

	//////////////////////////////
	// Configuration registers
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_cfg.width   <= RESET_WIDTH;
			o_cfg.height  <= RESET_HEIGHT;
			o_cfg.vset    <= '0;
			o_cfg.vol_att <= '0;
		end else if (i_io_sel && i_io_strobe && has_cmd) begin
			case (cmd)
				host_cmd_pkg::CMD_TIMING: begin
					// Porch and sync words are counted but not kept
					if (word_idx == 3'd0) begin
						o_cfg.width <= i_io_din[11:0];
					end
					if (word_idx == 3'd4) begin
						o_cfg.height <= i_io_din[11:0];
					end
				end
				host_cmd_pkg::CMD_VOLUME: begin
					o_cfg.vol_att <= i_io_din[4:0];
				end
				host_cmd_pkg::CMD_VSET: begin
					o_cfg.vset <= i_io_din[11:0];
				end
				default: begin
					// Unknown command, data is swallowed
				end
			endcase
		end
	end

endmodule

//--- hw/host_cmd_pkg.sv
// Host command port definitions
// Word format of the host stream and the command codes
// that the decoder acts on

package host_cmd_pkg;

	// One word on the host port
	typedef logic [15:0] io_word_t;

	// Command codes, low byte of the first word after select
	typedef enum logic [7:0] {
		CMD_TIMING = 8'h20,
		CMD_VOLUME = 8'h26,
		CMD_VSET   = 8'h27
	} cmd_t;

endpackage

//--- hw/mister_av_core.sv
// Host-facing video and audio controller
// Host command port, aspect-ratio display window and a
// cross-coupled stereo mixer, all on clk_sys

`timescale 1ns/1ps

module mister_av_core #(
	parameter av_types_pkg::coord_t RESET_WIDTH  = av_types_pkg::DEF_WIDTH,
	parameter av_types_pkg::coord_t RESET_HEIGHT = av_types_pkg::DEF_HEIGHT
) (
	input  logic                    clk_sys,
	input  logic                    resetd,

	// Host port
	input  logic                    i_io_sel,
	input  logic                    i_io_strobe,
	input  host_cmd_pkg::io_word_t  i_io_din,

	// Aspect ratio
	input  av_types_pkg::aspect_t   i_arx,
	input  av_types_pkg::aspect_t   i_ary,

	// Audio in
	input  av_types_pkg::sample_t   i_core_l,
	input  av_types_pkg::sample_t   i_core_r,
	input  av_types_pkg::sample_t   i_aux_l,
	input  av_types_pkg::sample_t   i_aux_r,
	input  logic                    i_audio_signed,
	input  av_types_pkg::mix_mode_t i_audio_mix,

	// Results
	output av_types_pkg::coord_t    o_hmin,
	output av_types_pkg::coord_t    o_hmax,
	output av_types_pkg::coord_t    o_vmin,
	output av_types_pkg::coord_t    o_vmax,
	output av_types_pkg::sample_t   o_audio_l,
	output av_types_pkg::sample_t   o_audio_r
);

	av_cfg_if cfg_bus ();

	// Each channel's pre output feeds the other channel
	av_types_pkg::sample_t pre_l;
	av_types_pkg::sample_t pre_r;

	host_cmd_decoder #(
		.RESET_WIDTH  (RESET_WIDTH),
		.RESET_HEIGHT (RESET_HEIGHT)
	) u_decoder (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_sel    (i_io_sel),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_cfg       (cfg_bus)
	);

	aspect_window u_window (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_cfg   (cfg_bus),
		.i_arx   (i_arx),
		.i_ary   (i_ary),
		.o_hmin  (o_hmin),
		.o_hmax  (o_hmax),
		.o_vmin  (o_vmin),
		.o_vmax  (o_vmax)
	);

	audio_channel_mix u_mix_l (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_core   (i_core_l),
		.i_aux    (i_aux_l),
		.i_pre    (pre_r),
		.i_signed (i_audio_signed),
		.i_mix    (i_audio_mix),
		.i_cfg    (cfg_bus),
		.o_pre    (pre_l),
		.o_out    (o_audio_l)
	);

	audio_channel_mix u_mix_r (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_core   (i_core_r),
		.i_aux    (i_aux_r),
		.i_pre    (pre_l),
		.i_signed (i_audio_signed),
		.i_mix    (i_audio_mix),
		.i_cfg    (cfg_bus),
		.o_pre    (pre_r),
		.o_out    (o_audio_r)
	);

endmodule

//--- mister_av_core.f
hw/av_types_pkg.sv
hw/host_cmd_pkg.sv
hw/av_cfg_if.sv
hw/host_cmd_decoder.sv
hw/aspect_window.sv
hw/audio_channel_mix.sv
hw/mister_av_core.sv
testbench/mister_av_core_assertions.sv
testbench/tb_mister_av_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the A/V controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_mister_av_core \
	-f mister_av_core.f \
	-o sim_tb

# The log decides the result, so a nonzero exit here must not stop the script
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

//--- testbench/mister_av_core_assertions.sv
// Protocol checks on the host command decoder
// Configuration registers move only after a strobe taken
// with select high, and never hold unknown values after reset

`timescale 1ns/1ps

module mister_av_core_assertions (
	input logic                 clk_sys,
	input logic                 resetd,
	input logic                 i_io_sel,
	input logic                 i_io_strobe,
	input av_types_pkg::coord_t i_width,
	input av_types_pkg::coord_t i_height,
	input av_types_pkg::coord_t i_vset,
	input av_types_pkg::att_t   i_vol_att
);

	// Video size registers follow a taken strobe by one cycle
	assert property (@(posedge clk_sys) disable iff (resetd)
		!$past(i_io_sel && i_io_strobe) |->
			($stable(i_width) && $stable(i_height) && $stable(i_vset)))
		else $error("video configuration changed without a host strobe");

	assert property (@(posedge clk_sys) disable iff (resetd)
		!$past(i_io_sel) |-> $stable(i_vol_att))
		else $error("volume changed while select was low");

	assert property (@(posedge clk_sys)
		!resetd |-> !$isunknown({i_width, i_height, i_vset, i_vol_att}))
		else $error("configuration output unknown after reset");

endmodule

bind host_cmd_decoder mister_av_core_assertions u_assertions (
	.clk_sys     (clk_sys),
	.resetd      (resetd),
	.i_io_sel    (i_io_sel),
	.i_io_strobe (i_io_strobe),
	.i_width     (o_cfg.width),
	.i_height    (o_cfg.height),
	.i_vset      (o_cfg.vset),
	.i_vol_att   (o_cfg.vol_att)
);

//--- testbench/tb_mister_av_core.sv
// Testbench for the host-facing A/V controller
// Applies a table of host words, aspect terms and audio inputs,
// then compares the display window and both audio outputs
// against values derived from the command and mixer rules

`timescale 1ns/1ps

module tb_mister_av_core;

	typedef struct packed {
		logic [2:0]                         nwords;
		host_cmd_pkg::io_word_t [5:0]       words;
		av_types_pkg::aspect_t              arx;
		av_types_pkg::aspect_t              ary;
		av_types_pkg::sample_t              core_l;
		av_types_pkg::sample_t              core_r;
		av_types_pkg::sample_t              aux_l;
		av_types_pkg::sample_t              aux_r;
		logic                               sgn;
		av_types_pkg::mix_mode_t            mix;
		av_types_pkg::coord_t               exp_hmin;
		av_types_pkg::coord_t               exp_hmax;
		av_types_pkg::coord_t               exp_vmin;
		av_types_pkg::coord_t               exp_vmax;
		av_types_pkg::sample_t              exp_l;
		av_types_pkg::sample_t              exp_r;
	} row_t;

	logic clk_sys = 1'b0;
	logic resetd;
	logic io_sel;
	logic io_strobe;
	host_cmd_pkg::io_word_t io_din;
	av_types_pkg::aspect_t arx;
	av_types_pkg::aspect_t ary;
	av_types_pkg::sample_t core_l;
	av_types_pkg::sample_t core_r;
	av_types_pkg::sample_t aux_l;
	av_types_pkg::sample_t aux_r;
	logic audio_signed;
	av_types_pkg::mix_mode_t audio_mix;
	av_types_pkg::coord_t hmin;
	av_types_pkg::coord_t hmax;
	av_types_pkg::coord_t vmin;
	av_types_pkg::coord_t vmax;
	av_types_pkg::sample_t audio_l;
	av_types_pkg::sample_t audio_r;

	row_t tbl[$];
	row_t cur;
	integer seed = 60198;
	int cycles = 0;
	int cycle_limit = 0;

	mister_av_core i_mister_av_core (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_io_sel       (io_sel),
		.i_io_strobe    (io_strobe),
		.i_io_din       (io_din),
		.i_arx          (arx),
		.i_ary          (ary),
		.i_core_l       (core_l),
		.i_core_r       (core_r),
		.i_aux_l        (aux_l),
		.i_aux_r        (aux_r),
		.i_audio_signed (audio_signed),
		.i_audio_mix    (audio_mix),
		.o_hmin         (hmin),
		.o_hmax         (hmax),
		.o_vmin         (vmin),
		.o_vmax         (vmax),
		.o_audio_l      (audio_l),
		.o_audio_r      (audio_r)
	);

	always #20 clk_sys = ~clk_sys;

	// Run limit, sized from the table
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Test timed out after %0d cycles", cycles);
			$display(">>> FAIL");
			$fatal(1, "run did not complete");
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic int sext16(input av_types_pkg::sample_t s);
		return int'($signed(s));
	endfunction

	// Core plus aux, unsigned core is halved into the signed range
	function automatic int front_sum(input av_types_pkg::sample_t core,
			input av_types_pkg::sample_t aux, input logic sgn);
		int a1;
		a1 = sgn ? sext16(core) : (int'(core) >> 1);
		return a1 + sext16(aux);
	endfunction

	function automatic int blend(input int a2, input int pre, input av_types_pkg::mix_mode_t mix);
		case (mix)
			av_types_pkg::MIX_NONE: return a2;
			av_types_pkg::MIX_LOW:  return a2 - (a2 >>> 3) + (pre >>> 2);
			av_types_pkg::MIX_MID:  return a2 - (a2 >>> 2) + (pre >>> 1);
			default:                return (a2 >>> 1) + pre;
		endcase
	endfunction

	function automatic av_types_pkg::sample_t attenuate(input int a3, input av_types_pkg::att_t att);
		int a4;
		a4 = att[4] ? 0 : (a3 >>> att[3:0]);
		if (a4 > 32767) begin
			return 16'h7fff;
		end else if (a4 < -32768) begin
			return 16'h8000;
		end
		return a4[15:0];
	endfunction

	// Both channels, repeated until the crossfeed terms stop moving
	task automatic predict_audio(input row_t r, input av_types_pkg::att_t att,
			output av_types_pkg::sample_t out_l, output av_types_pkg::sample_t out_r);
		int a2_l;
		int a2_r;
		int pre_l;
		int pre_r;
		int iter;
		logic settled;
		a2_l = front_sum(r.core_l, r.aux_l, r.sgn);
		a2_r = front_sum(r.core_r, r.aux_r, r.sgn);
		pre_l = 0;
		pre_r = 0;
		iter = 0;
		settled = 1'b0;
		while (!settled && iter < 8) begin
			out_l = attenuate(blend(a2_l, pre_r, r.mix), att);
			out_r = attenuate(blend(a2_r, pre_l, r.mix), att);
			settled = (pre_l == (a2_l >>> 1)) && (pre_r == (a2_r >>> 1));
			pre_l = a2_l >>> 1;
			pre_r = a2_r >>> 1;
			iter++;
		end
	endtask

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	function automatic av_types_pkg::sample_t rand_sample();
		int r;
		r = $random(seed);
		return r[15:0];
	endfunction

	task automatic start_row(input logic [2:0] n, input host_cmd_pkg::io_word_t w0,
			input host_cmd_pkg::io_word_t w1, input host_cmd_pkg::io_word_t w2,
			input host_cmd_pkg::io_word_t w3, input host_cmd_pkg::io_word_t w4,
			input host_cmd_pkg::io_word_t w5);
		cur.nwords = n;
		cur.words = {w5, w4, w3, w2, w1, w0};
	endtask

	task automatic set_video(input av_types_pkg::aspect_t x, input av_types_pkg::aspect_t y,
			input av_types_pkg::coord_t h0, input av_types_pkg::coord_t h1,
			input av_types_pkg::coord_t v0, input av_types_pkg::coord_t v1);
		cur.arx = x;
		cur.ary = y;
		cur.exp_hmin = h0;
		cur.exp_hmax = h1;
		cur.exp_vmin = v0;
		cur.exp_vmax = v1;
	endtask

	task automatic set_audio(input av_types_pkg::sample_t cl, input av_types_pkg::sample_t cr,
			input av_types_pkg::sample_t al, input av_types_pkg::sample_t ar,
			input logic sgn, input av_types_pkg::mix_mode_t mix);
		cur.core_l = cl;
		cur.core_r = cr;
		cur.aux_l = al;
		cur.aux_r = ar;
		cur.sgn = sgn;
		cur.mix = mix;
	endtask

	task automatic build_table();
		int k;
		logic [2:0] w;
		row_t r;
		av_types_pkg::att_t att;
		av_types_pkg::sample_t exp_l;
		av_types_pkg::sample_t exp_r;
		cur = '0;
		// Defaults after reset, full 1080p area
		start_row(3'd0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
		set_video(8'd0, 8'd0, 12'd0, 12'd1919, 12'd0, 12'd1079);
		tbl.push_back(cur);
		start_row(3'd6, 16'h0020, 16'd1280, 16'd110, 16'd40, 16'd220, 16'd720);
		set_video(8'd0, 8'd0, 12'd0, 12'd1279, 12'd0, 12'd719);
		tbl.push_back(cur);
		// 4:3 pillarbox on 1080p
		start_row(3'd6, 16'h0020, 16'd1920, 16'd88, 16'd44, 16'd148, 16'd1080);
		set_video(8'd4, 8'd3, 12'd240, 12'd1679, 12'd0, 12'd1079);
		tbl.push_back(cur);
		// 32:9 letterbox
		start_row(3'd0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
		set_video(8'd32, 8'd9, 12'd0, 12'd1919, 12'd270, 12'd809);
		tbl.push_back(cur);
		start_row(3'd2, 16'h0027, 16'd540, 16'h0, 16'h0, 16'h0, 16'h0);
		set_video(8'd4, 8'd3, 12'd600, 12'd1319, 12'd270, 12'd809);
		tbl.push_back(cur);
		// Every mix mode, signed and unsigned
		for (k = 0; k < 8; k++) begin
			start_row(3'd2, 16'h0026, 16'(k % 5), 16'h0, 16'h0, 16'h0, 16'h0);
			set_audio(rand_sample(), rand_sample(), rand_sample(), rand_sample(),
				k[0], av_types_pkg::mix_mode_t'(k[2:1]));
			tbl.push_back(cur);
		end
		start_row(3'd2, 16'h0026, 16'h0010, 16'h0, 16'h0, 16'h0, 16'h0);
		set_audio(rand_sample(), rand_sample(), rand_sample(), rand_sample(),
			1'b1, av_types_pkg::MIX_MID);
		tbl.push_back(cur);
		// Saturation both ways
		start_row(3'd2, 16'h0026, 16'h0000, 16'h0, 16'h0, 16'h0, 16'h0);
		set_audio(16'h7fff, 16'h8000, 16'h7fff, 16'h8000, 1'b1, av_types_pkg::MIX_NONE);
		tbl.push_back(cur);
		// Volume command cut short, then an unknown command whose words
		// would land as volume data if the pending command survived
		start_row(3'd1, 16'h0026, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
		tbl.push_back(cur);
		start_row(3'd2, 16'h0055, 16'h0003, 16'h0, 16'h0, 16'h0, 16'h0);
		tbl.push_back(cur);

		att = '0;
		for (k = 0; k < tbl.size(); k++) begin
			r = tbl[k];
			if (r.words[0][7:0] == 8'h26) begin
				for (w = 3'd1; w < r.nwords; w++) begin
					att = r.words[w][4:0];
				end
			end
			predict_audio(r, att, exp_l, exp_r);
			r.exp_l = exp_l;
			r.exp_r = exp_r;
			tbl[k] = r;
		end
	endtask

	//////////////////////////////
	// Drive and compare
	//////////////////////////////

	task automatic apply_row(input row_t r);
		logic [2:0] w;
		@(negedge clk_sys);
		arx = r.arx;
		ary = r.ary;
		core_l = r.core_l;
		core_r = r.core_r;
		aux_l = r.aux_l;
		aux_r = r.aux_r;
		audio_signed = r.sgn;
		audio_mix = r.mix;
		if (r.nwords != 3'd0) begin
			for (w = 3'd0; w < r.nwords; w++) begin
				@(negedge clk_sys);
				io_sel = 1'b1;
				io_strobe = 1'b1;
				io_din = r.words[w];
			end
			@(negedge clk_sys);
			io_strobe = 1'b0;
			io_din = '0;
			@(negedge clk_sys);
			io_sel = 1'b0;
		end
	endtask

	task automatic check_coord(input string name, input av_types_pkg::coord_t exp,
			input av_types_pkg::coord_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
			$display(">>> FAIL");
			$fatal(1, "window mismatch on %s", name);
		end
	endtask

	task automatic check_sample(input string name, input av_types_pkg::sample_t exp,
			input av_types_pkg::sample_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t %s expected 16'h%04h got 16'h%04h", $time, name, exp, act);
			$display(">>> FAIL");
			$fatal(1, "audio mismatch on %s", name);
		end
	endtask

	initial begin
		row_t r;
		resetd = 1'b1;
		io_sel = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		arx = '0;
		ary = '0;
		core_l = '0;
		core_r = '0;
		aux_l = '0;
		aux_r = '0;
		audio_signed = 1'b0;
		audio_mix = av_types_pkg::MIX_NONE;
		build_table();
		cycle_limit = tbl.size() * 60 + 100;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		resetd = 1'b0;

		for (int i = 0; i < tbl.size(); i++) begin
			r = tbl[i];
			apply_row(r);
			// Window and mixer both settle well inside this hold
			repeat (32) @(negedge clk_sys);
			check_coord("o_hmin", r.exp_hmin, hmin);
			check_coord("o_hmax", r.exp_hmax, hmax);
			check_coord("o_vmin", r.exp_vmin, vmin);
			check_coord("o_vmax", r.exp_vmax, vmax);
			check_sample("o_audio_l", r.exp_l, audio_l);
			check_sample("o_audio_r", r.exp_r, audio_r);
			$display("Row %0d checked", i);
		end

		$display(">>> PASS");
		$finish;
	end

endmodule
